//--- dtlb.f
hdl/tlb_pkg.sv
hdl/dtlb_replacement_block.sv
hdl/dtlb_entry_array.sv
hdl/dtlb.sv
tests/dtlb_checker.sv
tests/tb_dtlb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the data TLB testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f dtlb.f --top-module tb_dtlb \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_dtlb > sim.log 2>&1
cat sim.log
grep -qF '*** PASSED ***' sim.log && exit 0 || exit 1

//--- tests/tb_dtlb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench top for the data TLB
module tb_dtlb;

  localparam int N = tlb_pkg::D_TLB_ENTRIES;
  localparam int VPN_W = tlb_pkg::VPN_W;
  localparam int PPN_W = tlb_pkg::PPN_W;
  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 5;
  localparam int RESP_TIMEOUT = 10;
  localparam int MAX_CYCLES = 5000;
  localparam int RANDOM_CYCLES = 400;

  logic               clk_i;
  logic               rst_ni;
  logic               lookup_valid_i;
  logic [VPN_W-1:0]   lookup_vpn_i;
  logic               fill_valid_i;
  tlb_pkg::tlb_fill_t fill_i;
  logic               flush_i;
  logic               resp_valid_o;
  tlb_pkg::tlb_resp_t resp_o;

  integer seed;
  int     test_cnt = 0;
  int     timeouts = 0;
  // Set once a wait expires so that later waits return at once
  logic   hung = 1'b0;

  dtlb #(
    .N_ENTRIES (N)
  ) UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lookup_valid_i (lookup_valid_i),
    .lookup_vpn_i   (lookup_vpn_i),
    .fill_valid_i   (fill_valid_i),
    .fill_i         (fill_i),
    .flush_i        (flush_i),
    .resp_valid_o   (resp_valid_o),
    .resp_o         (resp_o)
  );

  dtlb_checker #(
    .N (N)
  ) u_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lookup_valid_i (lookup_valid_i),
    .lookup_vpn_i   (lookup_vpn_i),
    .fill_valid_i   (fill_valid_i),
    .fill_i         (fill_i),
    .flush_i        (flush_i),
    .resp_valid_i   (resp_valid_o),
    .resp_i         (resp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Whole-run limit
  initial begin : watchdog
    for (int c = 0; c < MAX_CYCLES; c++) begin
      @(posedge clk_i);
    end
    $display("Timeout: simulation ran past %0d cycles", MAX_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  function automatic logic [VPN_W-1:0] rand_vpn();
    logic [31:0] r;
    r = $random(seed);
    return r[VPN_W-1:0];
  endfunction

  function automatic logic [PPN_W-1:0] rand_ppn();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi[PPN_W-33:0], lo};
  endfunction

  // Present in the model or in the fill about to be sampled
  function automatic logic is_present(input logic [VPN_W-1:0] vpn);
    logic found;
    found = fill_valid_i && !flush_i && (fill_i.vpn == vpn);
    for (int k = 0; k < N; k++) begin
      if (u_checker.m_valid[k] && u_checker.m_vpn[k] == vpn) found = 1'b1;
    end
    return found;
  endfunction

  function automatic logic [VPN_W-1:0] new_vpn();
    logic [VPN_W-1:0] vpn;
    vpn = rand_vpn();
    for (int t = 0; t < 64 && is_present(vpn); t++) vpn = rand_vpn();
    return vpn;
  endfunction

  // Random VPN out of the valid model entries
  function automatic logic [VPN_W-1:0] present_vpn();
    int          idx [N];
    int          cnt;
    logic [31:0] r;
    cnt = 0;
    for (int k = 0; k < N; k++) begin
      if (u_checker.m_valid[k]) begin
        idx[cnt] = k;
        cnt++;
      end
    end
    r = $random(seed);
    if (cnt == 0) return r[VPN_W-1:0];
    return u_checker.m_vpn[idx[int'(r[15:0]) % cnt]];
  endfunction

  task automatic drive(input logic lv, input logic [VPN_W-1:0] lvpn, input logic fv,
                       input logic [VPN_W-1:0] fvpn, input logic [PPN_W-1:0] fppn,
                       input logic fl);
    @(negedge clk_i);
    lookup_valid_i = lv;
    lookup_vpn_i   = lvpn;
    fill_valid_i   = fv;
    fill_i.vpn     = fvpn;
    fill_i.ppn     = fppn;
    flush_i        = fl;
  endtask

  task automatic idle();
    drive(1'b0, '0, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic fill(input logic [VPN_W-1:0] vpn);
    drive(1'b0, '0, 1'b1, vpn, rand_ppn(), 1'b0);
  endtask

  // Wait for the response strobe with a timeout while the inputs go idle
  task automatic wait_resp(input logic [VPN_W-1:0] vpn);
    logic got;
    got = 1'b0;
    if (!hung) begin
      for (int t = 0; t < RESP_TIMEOUT && !got; t++) begin
        @(negedge clk_i);
        lookup_valid_i = 1'b0;
        fill_valid_i   = 1'b0;
        flush_i        = 1'b0;
        got            = resp_valid_o;
      end
      if (!got) begin
        $display("Timeout: no lookup response for VPN %h within %0d cycles", vpn,
                 RESP_TIMEOUT);
        timeouts++;
        hung = 1'b1;
      end
    end
  endtask

  task automatic lookup(input logic [VPN_W-1:0] vpn);
    drive(1'b1, vpn, 1'b0, '0, '0, 1'b0);
    wait_resp(vpn);
  endtask

  task automatic report(input string name);
    test_cnt++;
    $display("Test %0d %s done, %0d errors so far", test_cnt, name,
             u_checker.err_cnt + timeouts);
  endtask

  task automatic cold_start_test();
    logic [VPN_W-1:0] vpns [N];
    // Every lookup misses in the empty array
    for (int k = 0; k < 3; k++) lookup(rand_vpn());
    for (int k = 0; k < N; k++) begin
      vpns[k] = new_vpn();
      fill(vpns[k]);
    end
    for (int k = 0; k < N; k++) lookup(vpns[k]);
    report("cold start and invalid-first");
  endtask

  task automatic plru_victim_test();
    logic [VPN_W-1:0] victim_vpn;
    for (int k = 0; k < 12; k++) lookup(present_vpn());
    victim_vpn = u_checker.m_vpn[u_checker.next_victim];
    fill(new_vpn());
    // Victim now misses and the rest still hit
    lookup(victim_vpn);
    for (int k = 0; k < N; k++) lookup(u_checker.m_vpn[k]);
    report("PLRU victim");
  endtask

  task automatic random_traffic_test();
    logic [31:0]      r;
    logic [VPN_W-1:0] lvpn;
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      r    = $random(seed);
      lvpn = r[2] ? present_vpn() : rand_vpn();
      // Lookup in 3 of 4 cycles and fill in 1 of 4
      drive(r[1:0] != 2'b00, lvpn, r[4:3] == 2'b00, new_vpn(), rand_ppn(), 1'b0);
    end
    idle();
    idle();
    report("random traffic");
  endtask

  task automatic flush_test();
    logic [VPN_W-1:0] old_vpns [N];
    logic [VPN_W-1:0] dropped_vpn;
    logic [VPN_W-1:0] fresh [3];
    for (int k = 0; k < N; k++) old_vpns[k] = u_checker.m_vpn[k];
    // Fill sampled with the flush gets dropped
    dropped_vpn = new_vpn();
    drive(1'b0, '0, 1'b1, dropped_vpn, rand_ppn(), 1'b1);
    idle();
    for (int k = 0; k < N; k++) lookup(old_vpns[k]);
    lookup(dropped_vpn);
    for (int k = 0; k < 3; k++) begin
      fresh[k] = new_vpn();
      fill(fresh[k]);
    end
    for (int k = 0; k < 3; k++) lookup(fresh[k]);
    report("flush");
  endtask

  task automatic lookup_fill_test();
    logic [VPN_W-1:0] x;
    logic [VPN_W-1:0] y;
    logic [VPN_W-1:0] victim_vpn;
    // Lookup of the VPN being filled misses and the next one hits
    x = new_vpn();
    drive(1'b1, x, 1'b1, x, rand_ppn(), 1'b0);
    wait_resp(x);
    lookup(x);
    for (int k = 0; k < N; k++) begin
      if (!u_checker.m_valid[u_checker.next_victim]) begin
        fill(new_vpn());
        idle();
      end
    end
    // Tree stays as it was when a hit and a fill share a cycle
    y = present_vpn();
    drive(1'b1, y, 1'b1, new_vpn(), rand_ppn(), 1'b0);
    wait_resp(y);
    victim_vpn = u_checker.m_vpn[u_checker.next_victim];
    fill(new_vpn());
    lookup(victim_vpn);
    for (int k = 0; k < N; k++) lookup(u_checker.m_vpn[k]);
    report("lookup and fill together");
  endtask

  initial begin : main
    seed           = 15130;
    rst_ni         = 1'b0;
    lookup_valid_i = 1'b0;
    lookup_vpn_i   = '0;
    fill_valid_i   = 1'b0;
    fill_i         = '0;
    flush_i        = 1'b0;
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clk_i);
    end
    rst_ni = 1'b1;
    idle();
    cold_start_test();
    plru_victim_test();
    random_traffic_test();
    flush_test();
    lookup_fill_test();
    idle();
    idle();
    $display("Summary: %0d tests, %0d checks, %0d mismatches, %0d timeouts", test_cnt,
             u_checker.check_cnt, u_checker.err_cnt, timeouts);
    if (u_checker.err_cnt == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/dtlb_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Reference model of the data TLB
// Watches the DUT ports, predicts each response and compares it one cycle later
module dtlb_checker #(
  parameter int N = tlb_pkg::D_TLB_ENTRIES
) (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      lookup_valid_i,
  input logic [tlb_pkg::VPN_W-1:0] lookup_vpn_i,
  input logic                      fill_valid_i,
  input tlb_pkg::tlb_fill_t        fill_i,
  input logic                      flush_i,
  // DUT response under check
  input logic                      resp_valid_i,
  input tlb_pkg::tlb_resp_t        resp_i
);

  // Model entries
  logic                      m_valid [N];
  logic [tlb_pkg::VPN_W-1:0] m_vpn [N];
  logic [tlb_pkg::PPN_W-1:0] m_ppn [N];
  // Heap-ordered tree where node i has children 2i+1 and 2i+2
  logic [N-2:0]              m_tree;

  // Entry the next fill would take
  int next_victim;

  // Response expected after the last edge
  logic               exp_valid;
  tlb_pkg::tlb_resp_t exp_resp;

  // No prediction exists before the first rising edge
  logic edge_seen = 1'b0;

  int check_cnt = 0;
  int err_cnt = 0;

  // Victim is the lowest invalid entry or the leaf reached by walking the tree
  function automatic int pick_victim();
    int node;
    int victim;
    victim = -1;
    for (int k = N - 1; k >= 0; k--) begin
      if (!m_valid[k]) victim = k;
    end
    if (victim < 0) begin
      node = 0;
      // 0 goes to the lower child, 1 to the upper child
      while (node < N - 1) begin
        node = 2 * node + 1 + int'(m_tree[node]);
      end
      victim = node - (N - 1);
    end
    return victim;
  endfunction

  // Every node on the path points away from the accessed entry
  function automatic void touch_entry(input int e);
    int node;
    int parent;
    node = e + N - 1;
    while (node > 0) begin
      parent = (node - 1) / 2;
      m_tree[parent] = (node == 2 * parent + 1);
      node = parent;
    end
  endfunction

  // Model step at each rising edge with the inputs sampled there
  always @(posedge clk_i or negedge rst_ni) begin : model_step
    int   hit_idx;
    int   victim;
    logic read;
    if (!rst_ni) begin
      for (int k = 0; k < N; k++) begin
        m_valid[k] = 1'b0;
        m_vpn[k]   = '0;
        m_ppn[k]   = '0;
      end
      m_tree      = '0;
      exp_valid   = 1'b0;
      exp_resp    = '0;
      next_victim = 0;
    end else begin
      hit_idx = -1;
      for (int k = 0; k < N; k++) begin
        if (m_valid[k] && m_vpn[k] == lookup_vpn_i) hit_idx = k;
      end
      read = lookup_valid_i && (hit_idx >= 0);
      // Answer reflects contents before this edge's fill or flush
      exp_valid    = lookup_valid_i;
      exp_resp     = '0;
      exp_resp.hit = read;
      if (read) exp_resp.ppn = m_ppn[hit_idx];
      victim = pick_victim();
      // Read and fill together leave the tree alone
      if (read != fill_valid_i) touch_entry(read ? hit_idx : victim);
      if (flush_i) begin
        for (int k = 0; k < N; k++) m_valid[k] = 1'b0;
      end else if (fill_valid_i) begin
        m_valid[victim] = 1'b1;
        m_vpn[victim]   = fill_i.vpn;
        m_ppn[victim]   = fill_i.ppn;
      end
      next_victim = pick_victim();
    end
    if (clk_i) edge_seen = 1'b1;
  end

  // Outputs are stable at the falling edge, reset values included
  always @(negedge clk_i) begin
    if (edge_seen) begin
      check_cnt++;
      if (resp_valid_i !== exp_valid) begin
        err_cnt++;
        $display("FAIL t=%0t resp_valid_o expected %0b got %0b", $time, exp_valid,
                 resp_valid_i);
      end
      if (resp_i.hit !== exp_resp.hit) begin
        err_cnt++;
        $display("FAIL t=%0t resp_o.hit expected %0b got %0b", $time, exp_resp.hit,
                 resp_i.hit);
      end
      if (resp_i.ppn !== exp_resp.ppn) begin
        err_cnt++;
        $display("FAIL t=%0t resp_o.ppn expected %h got %h", $time, exp_resp.ppn,
                 resp_i.ppn);
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dtlb.sv
`timescale 1ns/1ps
`default_nettype none

// Data TLB top level
// Lookup answered one cycle after the request strobe
module dtlb #(
  parameter int N_ENTRIES = tlb_pkg::D_TLB_ENTRIES
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Lookup request
  input  logic                      lookup_valid_i,
  input  logic [tlb_pkg::VPN_W-1:0] lookup_vpn_i,
  // Fill from L2 TLB or page walker
  input  logic                      fill_valid_i,
  input  tlb_pkg::tlb_fill_t        fill_i,
  // Level, clears all entries
  input  logic                      flush_i,
  // Lookup response
  output logic                      resp_valid_o,
  output tlb_pkg::tlb_resp_t        resp_o
);

  // Array state
  logic [N_ENTRIES-1:0]      valid_vec;
  logic [N_ENTRIES-1:0]      hit_vec;
  logic [tlb_pkg::PPN_W-1:0] hit_ppn;

  // Victim select for fills
  logic [N_ENTRIES-1:0] replace_vec;

  logic any_hit;
  logic tlb_read;

  // Response register
  tlb_pkg::tlb_resp_t resp_d;
  tlb_pkg::tlb_resp_t resp_q;
  logic               resp_valid_q;

  dtlb_entry_array #(
    .N (N_ENTRIES)
  ) u_entry_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_vpn_i  (lookup_vpn_i),
    .fill_valid_i  (fill_valid_i),
    .fill_i        (fill_i),
    .replace_vec_i (replace_vec),
    .flush_i       (flush_i),
    .valid_vec_o   (valid_vec),
    .hit_vec_o     (hit_vec),
    .hit_ppn_o     (hit_ppn)
  );

  // Tree only moves on lookups that hit
  assign any_hit  = |hit_vec;
  assign tlb_read = lookup_valid_i & any_hit;

  dtlb_replacement_block #(
    .N (N_ENTRIES)
  ) u_replacement_block (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .tlb_valid_vec_i         (valid_vec),
    .hit_vec_i               (hit_vec),
    .valid_tlb_read_i        (tlb_read),
    .valid_tlb_replacement_i (fill_valid_i),
    .replace_vec_o           (replace_vec)
  );

  // Response built from the array before this edge's fill or flush
  always_comb begin
    resp_d     = '0;
    resp_d.hit = tlb_read;
    if (lookup_valid_i) begin
      resp_d.ppn = hit_ppn;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      resp_q       <= '0;
    end else begin
      resp_valid_q <= lookup_valid_i;
      resp_q       <= resp_d;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

`default_nettype wire

//--- hdl/dtlb_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

// Fully associative storage of the data TLB
// Parallel VPN compare, one-hot fill write, global flush
module dtlb_entry_array #(
  parameter int N = tlb_pkg::D_TLB_ENTRIES
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Lookup side
  input  logic [tlb_pkg::VPN_W-1:0] lookup_vpn_i,
  // Fill side
  input  logic                      fill_valid_i,
  input  tlb_pkg::tlb_fill_t        fill_i,
  input  logic [N-1:0]              replace_vec_i,
  // Clears every valid bit
  input  logic                      flush_i,
  // Entry state
  output logic [N-1:0]              valid_vec_o,
  output logic [N-1:0]              hit_vec_o,
  output logic [tlb_pkg::PPN_W-1:0] hit_ppn_o
);

  // VPN/PPN pair per entry
  tlb_pkg::tlb_fill_t entry_q [N];

  // Valid bit per entry
  logic [N-1:0] valid_q;

  // Entries written at the next edge
  logic [N-1:0] write_vec;
  logic         fill_en;

  // Compare results
  logic [N-1:0]              hit_vec;
  logic [tlb_pkg::PPN_W-1:0] ppn_sel;

  // Flush wins over a fill in the same cycle
  assign fill_en   = fill_valid_i & ~flush_i;
  assign write_vec = replace_vec_i & {N{fill_en}};

  // Valid bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else begin
      // Write select is one-hot, so at most one bit gets set
      valid_q <= valid_q | write_vec;
    end
  end

  // Entry payload
  for (genvar i = 0; i < N; i++) begin : gen_entry
    always_ff @(posedge clk_i) begin
      if (write_vec[i]) begin
        entry_q[i] <= fill_i;
      end
    end
  end

  // Parallel compare against every valid entry
  always_comb begin
    hit_vec = '0;
    for (int k = 0; k < N; k++) begin
      hit_vec[k] = valid_q[k] & (entry_q[k].vpn == lookup_vpn_i);
    end
  end

  // PPN mux as AND-OR over the hit vector
  // No duplicates are filled, so at most one term is nonzero
  always_comb begin
    ppn_sel = '0;
    for (int k = 0; k < N; k++) begin
      ppn_sel = ppn_sel | (entry_q[k].ppn & {tlb_pkg::PPN_W{hit_vec[k]}});
    end
  end

  assign valid_vec_o = valid_q;
  assign hit_vec_o   = hit_vec;
  assign hit_ppn_o   = ppn_sel;

endmodule

`default_nettype wire

//--- hdl/dtlb_replacement_block.sv
`timescale 1ns/1ps
`default_nettype none

// Tree pseudo-LRU victim selection for the data TLB
// Invalid entries are always filled first, lowest index wins
module dtlb_replacement_block #(
  parameter int N = tlb_pkg::D_TLB_ENTRIES
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  // Entry state from the array
  input  logic [N-1:0] tlb_valid_vec_i,
  input  logic [N-1:0] hit_vec_i,
  // Access strobes
  input  logic         valid_tlb_read_i,
  input  logic         valid_tlb_replacement_i,
  // One-hot write select for the next fill
  output logic [N-1:0] replace_vec_o
);

  // Node count of the tree
  localparam int NODES = N - 1;
  // First node whose children are entries
  localparam int LEAF_BASE = (N / 2) - 1;

  // Tree node bits, heap-ordered
  // Node i has children 2i+1 (lower half) and 2i+2 (upper half)
  logic [NODES-1:0] node_q;
  logic [NODES-1:0] node_d;
  logic [NODES-1:0] node_en;

  // Decoder enable reaching each node from the root
  logic [NODES-1:0] dec_en;

  // Candidate victims
  logic [N-1:0] plru_vec;
  logic [N-1:0] invalid_first_vec;
  logic [N-1:0] replace_vec;

  // Entry touched in this cycle
  logic [N-1:0] access_vec;
  logic         tree_upd;
  logic         all_valid;

  // Update only when exactly one of read and fill happens
  assign tree_upd = valid_tlb_read_i ^ valid_tlb_replacement_i;

  // Hit vector on a read, own victim on a fill
  always_comb begin
    access_vec = '0;
    if (tree_upd) begin
      access_vec = valid_tlb_read_i ? hit_vec_i : replace_vec;
    end
  end

  // Decoder levels, top-down
  // A 0 bit steers the enable into the lower half
  always_comb begin
    dec_en    = '0;
    dec_en[0] = 1'b1;
    for (int i = 0; i < LEAF_BASE; i++) begin
      dec_en[2*i+1] = dec_en[i] & ~node_q[i];
      dec_en[2*i+2] = dec_en[i] &  node_q[i];
    end
  end

  // Last decoder level picks the entry
  always_comb begin
    plru_vec = '0;
    for (int k = 0; k < N / 2; k++) begin
      plru_vec[2*k]   = dec_en[LEAF_BASE+k] & ~node_q[LEAF_BASE+k];
      plru_vec[2*k+1] = dec_en[LEAF_BASE+k] &  node_q[LEAF_BASE+k];
    end
  end

  // Node enables and next values, bottom-up
  // At most one child of an enabled node is set, so the lower one gives the direction
  always_comb begin
    node_en = '0;
    node_d  = '0;
    // Nodes right above the entries
    for (int k = 0; k < N / 2; k++) begin
      node_en[LEAF_BASE+k] = access_vec[2*k] | access_vec[2*k+1];
      // Lower entry accessed, so point to the upper one
      node_d[LEAF_BASE+k]  = access_vec[2*k];
    end
    // Inner nodes follow the enables of their children
    for (int i = LEAF_BASE - 1; i >= 0; i--) begin
      node_en[i] = node_en[2*i+1] | node_en[2*i+2];
      node_d[i]  = node_en[2*i+1];
    end
  end

  // One enabled flip-flop per node
  for (genvar i = 0; i < NODES; i++) begin : gen_node
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        node_q[i] <= 1'b0;
      end else if (node_en[i]) begin
        node_q[i] <= node_d[i];
      end
    end
  end

  // Priority encoder, lowest invalid index
  always_comb begin
    invalid_first_vec = '0;
    for (int k = N - 1; k >= 0; k--) begin
      if (!tlb_valid_vec_i[k]) begin
        invalid_first_vec    = '0;
        invalid_first_vec[k] = 1'b1;
      end
    end
  end

  // PLRU only once the array is full
  assign all_valid   = &tlb_valid_vec_i;
  assign replace_vec = all_valid ? plru_vec : invalid_first_vec;

  assign replace_vec_o = replace_vec;

endmodule

`default_nettype wire

//--- hdl/tlb_pkg.sv
`default_nettype none

// Shared widths, sizes and payload types of the data TLB
package tlb_pkg;

  // Sv39 virtual page number
  // Three 9-bit VPN fields of the 39-bit virtual address
  parameter int VPN_W = 27;

  // Physical page number
  // 56-bit physical address minus the 12-bit page offset
  parameter int PPN_W = 44;

  // Default entry count of the data TLB
  // Must be a power of two, at least 2, for the PLRU tree
  parameter int D_TLB_ENTRIES = 8;

  // Fill payload coming from the L2 TLB or page walker
  // VPN in the upper bits, PPN in the lower bits
  typedef struct packed {
    logic [VPN_W-1:0] vpn;
    logic [PPN_W-1:0] ppn;
  } tlb_fill_t;

  // Lookup answer returned one cycle after the request
  // PPN is all zeros on a miss
  typedef struct packed {
    logic             hit;
    logic [PPN_W-1:0] ppn;
  } tlb_resp_t;

  // Total payload widths, handy for sizing
  parameter int FILL_W = VPN_W + PPN_W;
  parameter int RESP_W = 1 + PPN_W;

  // 4 KiB pages only
  parameter int PAGE_OFFSET_W = 12;

endpackage

`default_nettype wire
